/* verification/dcache_input.txt */
// test op(0 read 1 write) addr strb wdata exp_rdata exp_mem_writes exp_mem_reads, all hex
// exp_rdata is checked on reads only
1 0 00000100 00 0000000000000000 0000010000000100 0 1
1 0 00000104 00 0000000000000000 0000010000000100 0 0
2 1 00000100 0f aaaabbbbccccdddd 0000000000000000 0 0
2 0 00000100 00 0000000000000000 00000100ccccdddd 0 0
3 1 00000208 c0 1122334455667788 0000000000000000 0 1
3 0 00000208 00 0000000000000000 1122020800000208 0 0
4 0 00001010 00 0000000000000000 0000101000001010 0 1
4 0 00002010 00 0000000000000000 0000201000002010 0 1
4 0 00001010 00 0000000000000000 0000101000001010 0 0
4 0 00003010 00 0000000000000000 0000301000003010 0 1
4 0 00001010 00 0000000000000000 0000101000001010 0 0
4 0 00002010 00 0000000000000000 0000201000002010 0 1
5 1 00001018 0f deadbeefcafef00d 0000000000000000 0 1
5 0 00002018 00 0000000000000000 0000201800002018 0 1
5 0 00003018 00 0000000000000000 0000301800003018 1 1
5 0 00001018 00 0000000000000000 00001018cafef00d 0 1
6 0 00000100 00 0000000000000000 00000100ccccdddd 0 0
6 1 00003018 f0 5555666677778888 0000000000000000 0 0
6 0 00002018 00 0000000000000000 0000201800002018 0 1
6 0 00004018 00 0000000000000000 0000401800004018 1 1
6 0 00003018 00 0000000000000000 5555666600003018 0 1

/* compile.f */
rtl/dcache_pkg.sv
rtl/dcache_cpu_port.sv
rtl/dcache_ctrl.sv
rtl/dcache_data_array.sv
rtl/dcache_mem_port.sv
rtl/dcache_top.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f compile.f

./obj_dir/Vdcache_tb | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

/* verification/dcache_tb.sv */
//////////////////////////////////////////////////
// data cache testbench
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

  localparam int INDEX_WIDTH  = 6;
  localparam int RESET_CYCLES = 10;
  localparam int OP_CYCLES    = 40;  // budget per operation
  localparam int MAX_OPS      = 64;
  localparam int FIELDS       = 8;   // tokens per line of the input file

  logic  clk;
  logic  rst;
  logic  cpu_req;
  logic  cpu_we;
  addr_t cpu_addr;
  strb_t cpu_strb;
  data_t cpu_wdata;
  logic  cpu_ack;
  data_t cpu_rdata;
  logic  mem_req;
  logic  mem_we;
  addr_t mem_addr;
  data_t mem_wdata;
  logic  mem_ack;
  data_t mem_rdata;

  logic [63:0] vec_mem [FIELDS*MAX_OPS];
  data_t       mem_words [addr_t];  // words written back by the cache
  logic [31:0] lcg_state;
  int          wr_count;
  int          rd_count;
  int          errors;
  int          checks;
  int          num_tests;
  int          cycle_count = 0;
  int          cycle_limit;

  dcache_top #(.INDEX_WIDTH(INDEX_WIDTH)) i_dcache_top (
    .clk, .rst, .cpu_req_i(cpu_req), .cpu_we_i(cpu_we), .cpu_addr_i(cpu_addr),
    .cpu_strb_i(cpu_strb), .cpu_wdata_i(cpu_wdata), .cpu_ack_o(cpu_ack),
    .cpu_rdata_o(cpu_rdata), .mem_req_o(mem_req), .mem_we_o(mem_we),
    .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack),
    .mem_rdata_i(mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run stopped after %0d cycles, the cache did not answer in time", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;  // clear of the edge
  endtask

  task automatic random_delay();
    lcg_state = lcg_next(lcg_state);
    repeat (lcg_state[17:16]) begin
      next_cycle();
    end
  endtask

  task automatic check_value(input string name, input data_t exp, input data_t got);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic report_test(input logic [63:0] num, input int fails);
    num_tests++;
    if (fails == 0) begin
      $display("test %0d passed", num);
    end else begin
      $display("test %0d failed with %0d errors", num, fails);
    end
  endtask

  // one cpu transaction, counts memory traffic while it runs
  task automatic run_op(input int base);
    logic is_write;
    int   wr_start;
    int   rd_start;
    is_write  = vec_mem[base+1][0];
    wr_start  = wr_count;
    rd_start  = rd_count;
    cpu_we    = is_write;
    cpu_addr  = vec_mem[base+2][31:0];
    cpu_strb  = vec_mem[base+3][7:0];
    cpu_wdata = vec_mem[base+4];
    cpu_req   = 1'b1;
    while (!cpu_ack) begin
      next_cycle();
    end
    if (!is_write) begin
      check_value("cpu_rdata_o", vec_mem[base+5], cpu_rdata);
    end
    check_value("mem write count", vec_mem[base+6], 64'(wr_count - wr_start));
    check_value("mem read count", vec_mem[base+7], 64'(rd_count - rd_start));
    cpu_req = 1'b0;
    while (cpu_ack) begin
      next_cycle();
    end
  endtask

  // memory model, four-phase with random ack delays
  initial begin
    mem_ack   = 1'b0;
    mem_rdata = '0;
    wr_count  = 0;
    rd_count  = 0;
    lcg_state = 32'h8551_4245;
    forever begin
      next_cycle();
      if (mem_req) begin
        random_delay();
        if (mem_we) begin
          mem_words[mem_addr] = mem_wdata;
          wr_count++;
        end else begin
          // unwritten words read as their own address twice
          mem_rdata = mem_words.exists(mem_addr) ? mem_words[mem_addr] :
                      {mem_addr, mem_addr};
          rd_count++;
        end
        mem_ack = 1'b1;
        while (mem_req) begin
          next_cycle();
        end
        random_delay();
        mem_ack = 1'b0;
      end
    end
  end

  initial begin
    int          op_count;
    int          test_start;
    logic [63:0] cur_test;
    rst       = 1'b1;
    cpu_req   = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_strb  = '0;
    cpu_wdata = '0;
    errors    = 0;
    checks    = 0;
    num_tests = 0;
    for (int i = 0; i < FIELDS*MAX_OPS; i++) begin
      vec_mem[i] = '1;  // unused lines
    end
    $readmemh("verification/dcache_input.txt", vec_mem);
    op_count = 0;
    while ((op_count < MAX_OPS) && (vec_mem[op_count*FIELDS] != '1)) begin
      op_count++;
    end
    cycle_limit = RESET_CYCLES + op_count * OP_CYCLES;
    repeat (RESET_CYCLES) begin
      next_cycle();
    end
    rst = 1'b0;
    if (op_count == 0) begin
      $display("no operations found in the input file");
      errors++;
    end
    cur_test   = vec_mem[0];
    test_start = 0;
    for (int k = 0; k < op_count; k++) begin
      if (vec_mem[k*FIELDS] != cur_test) begin
        report_test(cur_test, errors - test_start);
        cur_test   = vec_mem[k*FIELDS];
        test_start = errors;
      end
      run_op(k * FIELDS);
    end
    if (op_count > 0) begin
      report_test(cur_test, errors - test_start);
    end
    $display("%0d tests, %0d checks, %0d failed", num_tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/dcache_assert.sv */
//////////////////////////////////////////////////
// cache handshake assertions
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dcache_assert import dcache_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  cpu_req_i,
  input logic  cpu_ack_o,
  input logic  mem_req_o,
  input logic  mem_we_o,
  input addr_t mem_addr_o,
  input data_t mem_wdata_o,
  input logic  mem_ack_i
);

  // requester may drop req once it has seen ack high
  cpu_req_held: assert property (@(posedge clk) disable iff (rst)
    $fell(cpu_req_i) |-> cpu_ack_o) else $error("cpu req dropped before ack");

  mem_req_held: assert property (@(posedge clk) disable iff (rst)
    mem_req_o && !mem_ack_i |=> mem_req_o) else $error("mem req dropped before ack");

  // payload fixed for the whole request phase
  mem_payload_stable: assert property (@(posedge clk) disable iff (rst)
    $past(mem_req_o) && mem_req_o |-> $stable({mem_we_o, mem_addr_o, mem_wdata_o}))
    else $error("mem payload changed during request");

  mem_req_after_ack: assert property (@(posedge clk) disable iff (rst)
    !mem_req_o && mem_ack_i |=> !mem_req_o) else $error("mem req rose with ack high");

  reset_quiet: assert property (@(posedge clk)
    rst |=> !cpu_ack_o && !mem_req_o) else $error("handshake active after reset");

endmodule

bind dcache_top dcache_assert i_dcache_assert (
  .clk(clk), .rst(rst), .cpu_req_i(cpu_req_i), .cpu_ack_o(cpu_ack_o),
  .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
  .mem_wdata_o(mem_wdata_o), .mem_ack_i(mem_ack_i)
);

`default_nettype wire

/* rtl/dcache_top.sv */
//////////////////////////////////////////////////
// write-back data cache top
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  cpu_req_i,
  input  logic  cpu_we_i,
  input  addr_t cpu_addr_i,
  input  strb_t cpu_strb_i,
  input  data_t cpu_wdata_i,
  output logic  cpu_ack_o,
  output data_t cpu_rdata_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  input  logic  mem_ack_i,
  input  data_t mem_rdata_i
);

  // cpu port to controller
  logic  start;
  logic  req_we;
  addr_t req_addr;
  strb_t req_strb;
  data_t req_wdata;
  logic  done;
  data_t done_rdata;

  // controller to data array
  logic                   rd_en;
  logic                   wr_en;
  logic                   way;
  logic [INDEX_WIDTH-1:0] index;
  strb_t                  wr_mask;
  data_t                  wr_data;
  data_t                  rd_word;

  // controller to memory port
  logic  cmd_valid;
  logic  cmd_we;
  addr_t cmd_addr;
  data_t cmd_wdata;
  logic  cmd_done;
  data_t cmd_rdata;

  dcache_cpu_port i_cpu_port (
    .clk, .rst, .cpu_req_i, .cpu_we_i, .cpu_addr_i, .cpu_strb_i, .cpu_wdata_i,
    .done_i(done), .rdata_i(done_rdata), .cpu_ack_o, .cpu_rdata_o,
    .start_o(start), .we_o(req_we), .addr_o(req_addr), .strb_o(req_strb),
    .wdata_o(req_wdata)
  );

  dcache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) i_ctrl (
    .clk, .rst, .start_i(start), .we_i(req_we), .addr_i(req_addr),
    .strb_i(req_strb), .wdata_i(req_wdata), .rd_word_i(rd_word),
    .cmd_done_i(cmd_done), .cmd_rdata_i(cmd_rdata), .done_o(done),
    .rdata_o(done_rdata), .rd_en_o(rd_en), .wr_en_o(wr_en), .way_o(way),
    .index_o(index), .wr_mask_o(wr_mask), .wr_data_o(wr_data),
    .cmd_valid_o(cmd_valid), .cmd_we_o(cmd_we), .cmd_addr_o(cmd_addr),
    .cmd_wdata_o(cmd_wdata)
  );

  dcache_data_array #(.INDEX_WIDTH(INDEX_WIDTH)) i_data_array (
    .clk, .rd_en_i(rd_en), .wr_en_i(wr_en), .way_i(way), .index_i(index),
    .wr_mask_i(wr_mask), .wr_data_i(wr_data), .rd_word_o(rd_word)
  );

  dcache_mem_port i_mem_port (
    .clk, .rst, .cmd_valid_i(cmd_valid), .cmd_we_i(cmd_we), .cmd_addr_i(cmd_addr),
    .cmd_wdata_i(cmd_wdata), .mem_ack_i, .mem_rdata_i, .cmd_done_o(cmd_done),
    .cmd_rdata_o(cmd_rdata), .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o
  );

endmodule

`default_nettype wire

/* rtl/dcache_mem_port.sv */
//////////////////////////////////////////////////
// cache memory handshake port
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_port import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  cmd_valid_i,
  input  logic  cmd_we_i,
  input  addr_t cmd_addr_i,
  input  data_t cmd_wdata_i,
  input  logic  mem_ack_i,
  input  data_t mem_rdata_i,
  output logic  cmd_done_o,
  output data_t cmd_rdata_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o
);

  typedef enum logic [1:0] {
    MP_IDLE,
    MP_REQ,      // req high, waiting for ack
    MP_RELEASE   // req dropped, waiting for ack low
  } mem_phase_e;

  mem_phase_e phase_q;

  assign mem_req_o = (phase_q == MP_REQ);

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q    <= MP_IDLE;
      cmd_done_o <= 1'b0;
    end else begin
      cmd_done_o <= 1'b0;
      case (phase_q)
        MP_IDLE: if (cmd_valid_i) phase_q <= MP_REQ;
        MP_REQ: if (mem_ack_i) phase_q <= MP_RELEASE;
        MP_RELEASE: if (!mem_ack_i) begin
          cmd_done_o <= 1'b1;
          phase_q    <= MP_IDLE;
        end
        default: phase_q <= MP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((phase_q == MP_IDLE) && cmd_valid_i) begin
      mem_we_o    <= cmd_we_i;
      mem_addr_o  <= cmd_addr_i;
      mem_wdata_o <= cmd_wdata_i;
    end
    if ((phase_q == MP_REQ) && mem_ack_i) begin
      cmd_rdata_o <= mem_rdata_i;  // read data valid with ack
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_data_array.sv */
//////////////////////////////////////////////////
// two way cache data store
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dcache_data_array import dcache_pkg::*; #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                   clk,
  input  logic                   rd_en_i,
  input  logic                   wr_en_i,
  input  logic                   way_i,
  input  logic [INDEX_WIDTH-1:0] index_i,
  input  strb_t                  wr_mask_i,
  input  data_t                  wr_data_i,
  output data_t                  rd_word_o
);

  localparam int SETS = 1 << INDEX_WIDTH;

  data_t bank_q [2][SETS];  // one bank per way

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (wr_mask_i[b]) begin
          bank_q[way_i][index_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
    // same cycle write gives the old word
    if (rd_en_i) begin
      rd_word_o <= bank_q[way_i][index_i];
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_ctrl.sv */
//////////////////////////////////////////////////
// cache tags and miss control
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  logic                   we_i,
  input  addr_t                  addr_i,
  input  strb_t                  strb_i,
  input  data_t                  wdata_i,
  input  data_t                  rd_word_i,
  input  logic                   cmd_done_i,
  input  data_t                  cmd_rdata_i,
  output logic                   done_o,
  output data_t                  rdata_o,
  output logic                   rd_en_o,
  output logic                   wr_en_o,
  output logic                   way_o,
  output logic [INDEX_WIDTH-1:0] index_o,
  output strb_t                  wr_mask_o,
  output data_t                  wr_data_o,
  output logic                   cmd_valid_o,
  output logic                   cmd_we_o,
  output addr_t                  cmd_addr_o,
  output data_t                  cmd_wdata_o
);

  localparam int SETS      = 1 << INDEX_WIDTH;
  localparam int TAG_WIDTH = $bits(addr_t) - INDEX_WIDTH - OFFSET_WIDTH;

  ctrl_state_e state_q;

  logic [TAG_WIDTH-1:0] tag_q [2][SETS];
  logic [SETS-1:0]      valid_q [2];
  logic [SETS-1:0]      dirty_q [2];
  logic [SETS-1:0]      lru_q;     // least recently used way per set
  logic                 way_q;     // way chosen in lookup
  logic                 sent_q;    // memory command in flight
  logic                 rd_hit_q;  // read hit, word comes from array

  logic [INDEX_WIDTH-1:0] idx;
  logic [TAG_WIDTH-1:0]   tag_in;
  logic                   hit0;
  logic                   hit1;
  logic                   hit;
  logic                   hit_way;
  logic                   victim;
  logic                   victim_dirty;
  logic                   sel_way;

  assign idx    = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
  assign tag_in = addr_i[$bits(addr_t)-1 -: TAG_WIDTH];

  assign hit0    = valid_q[0][idx] && (tag_q[0][idx] == tag_in);
  assign hit1    = valid_q[1][idx] && (tag_q[1][idx] == tag_in);
  assign hit     = hit0 | hit1;
  assign hit_way = ~hit0;

  // invalid ways first, way 0 before way 1, else lru
  assign victim       = !valid_q[0][idx] ? 1'b0 :
                        !valid_q[1][idx] ? 1'b1 : lru_q[idx];
  assign victim_dirty = valid_q[victim][idx] && dirty_q[victim][idx];
  assign sel_way      = hit ? hit_way : victim;

  // data array access
  assign way_o     = (state_q == LOOKUP) ? sel_way : way_q;
  assign index_o   = idx;
  assign rd_en_o   = (state_q == LOOKUP) && (hit ? !we_i : victim_dirty);
  assign wr_en_o   = ((state_q == LOOKUP) && hit && we_i) ||
                     ((state_q == REFILL) && cmd_done_i) ||
                     (state_q == WRITE);
  assign wr_mask_o = (state_q == REFILL) ? '1 : strb_i;  // refill writes whole word
  assign wr_data_o = (state_q == REFILL) ? cmd_rdata_i : wdata_i;

  // memory commands, victim word read during lookup
  assign cmd_valid_o = ((state_q == EVICT) || (state_q == REFILL)) && !sent_q;
  assign cmd_we_o    = (state_q == EVICT);
  assign cmd_addr_o  = (state_q == EVICT) ?
                       {tag_q[way_q][idx], idx, {OFFSET_WIDTH{1'b0}}} : addr_i;
  assign cmd_wdata_o = rd_word_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      sent_q  <= 1'b0;
      done_o  <= 1'b0;
      lru_q   <= '0;
      valid_q <= '{default: '0};
      dirty_q <= '{default: '0};
    end else begin
      done_o <= 1'b0;
      if (cmd_valid_o) begin
        sent_q <= 1'b1;
      end
      if (cmd_done_i) begin
        sent_q <= 1'b0;
      end
      case (state_q)
        IDLE: if (start_i) state_q <= LOOKUP;
        LOOKUP: begin
          if (hit) begin
            lru_q[idx] <= ~hit_way;
            if (we_i) begin
              dirty_q[hit_way][idx] <= 1'b1;  // merged this cycle
            end
            state_q <= DONE;
          end else if (victim_dirty) begin
            state_q <= EVICT;
          end else begin
            state_q <= REFILL;
          end
        end
        EVICT: if (cmd_done_i) state_q <= REFILL;
        REFILL: if (cmd_done_i) begin
          valid_q[way_q][idx] <= 1'b1;
          dirty_q[way_q][idx] <= 1'b0;
          lru_q[idx]          <= ~way_q;
          state_q             <= we_i ? WRITE : DONE;
        end
        WRITE: begin
          dirty_q[way_q][idx] <= 1'b1;
          state_q             <= DONE;
        end
        DONE: begin
          done_o  <= 1'b1;
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == LOOKUP) begin
      way_q    <= sel_way;
      rd_hit_q <= hit && !we_i;
    end
    if ((state_q == REFILL) && cmd_done_i) begin
      tag_q[way_q][idx] <= tag_in;
      rdata_o           <= cmd_rdata_i;  // miss returns the fetched word
    end
    if ((state_q == DONE) && rd_hit_q) begin
      rdata_o <= rd_word_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_cpu_port.sv */
//////////////////////////////////////////////////
// cache cpu handshake port
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dcache_cpu_port import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  cpu_req_i,
  input  logic  cpu_we_i,
  input  addr_t cpu_addr_i,
  input  strb_t cpu_strb_i,
  input  data_t cpu_wdata_i,
  input  logic  done_i,
  input  data_t rdata_i,
  output logic  cpu_ack_o,
  output data_t cpu_rdata_o,
  output logic  start_o,
  output logic  we_o,
  output addr_t addr_o,
  output strb_t strb_o,
  output data_t wdata_o
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_BUSY,   // waiting on controller
    PH_ACKED   // waiting for req to drop
  } phase_e;

  phase_e phase_q;

  assign cpu_ack_o = (phase_q == PH_ACKED);

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q <= PH_IDLE;
      start_o <= 1'b0;
    end else begin
      start_o <= 1'b0;
      case (phase_q)
        PH_IDLE: if (cpu_req_i) begin
          start_o <= 1'b1;
          phase_q <= PH_BUSY;
        end
        PH_BUSY: if (done_i) phase_q <= PH_ACKED;
        PH_ACKED: if (!cpu_req_i) phase_q <= PH_IDLE;
        default: phase_q <= PH_IDLE;
      endcase
    end
  end

  // request held for the controller until the next one
  always_ff @(posedge clk) begin
    if ((phase_q == PH_IDLE) && cpu_req_i) begin
      we_o    <= cpu_we_i;
      addr_o  <= {cpu_addr_i[$bits(addr_t)-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
      strb_o  <= cpu_strb_i;
      wdata_o <= cpu_wdata_i;
    end
    if (done_i) begin
      cpu_rdata_o <= rdata_i;  // stays until next done
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_pkg.sv */
//////////////////////////////////////////////////
// data cache shared types
//////////////////////////////////////////////////
`default_nettype none

package dcache_pkg;

  localparam int ADDR_WIDTH   = 32;
  localparam int DATA_WIDTH   = 64;
  localparam int STRB_WIDTH   = DATA_WIDTH / 8;
  localparam int OFFSET_WIDTH = 3;  // byte within word

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;  // one bit per byte

  // controller sequence, hit path is IDLE LOOKUP DONE
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT,   // write back dirty victim
    REFILL,  // fetch line from memory
    WRITE,   // merge store after refill
    DONE
  } ctrl_state_e;

endpackage

`default_nettype wire
